// File: files.f
hw/exu_wb_pkg.sv
hw/wb_pipe_ctl.sv
hw/restore_ctl.sv
hw/irf_port_arb.sv
hw/sr_access.sv
hw/exu_wb_top.sv
tb/exu_wb_sva.sv
tb/tb_exu_wb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the writeback control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_exu_wb -f files.f -o sim_exu_wb
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_exu_wb +verilator+error+limit+10000 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Finished with no errors"; then
   exit 0
fi
exit 1

// File: tb/tb_exu_wb.sv
// Checking lives in the bound assertion module; this drives directed then random traffic
`timescale 1ns/1ps

module tb_exu_wb import exu_wb_pkg::*; ();

   logic                 clk;
   logic                 reset;
   logic                 wen_d;
   logic                 wsr_d;
   sr_addr_u             sraddr_d;
   logic                 return_d;
   logic                 kill_e;
   logic                 inst_vld_e;
   logic                 inst_vld_w;
   logic                 restore_e;
   logic                 fill_e;
   irf_tgt_t             tgt_m;
   logic                 kill_m;
   logic                 flush_w;
   logic                 early_flush_w;
   logic                 flush_w1;
   logic [TID_W-1:0]     tid_w1;
   ld_ret_t              ld_g;
   logic                 ld_miss_g2;
   muldiv_wb_t           muldiv_g;
   win_state_t           win_d;
   logic [7:0]           cc_d;
   irf_wr_t              irf_w1;
   irf_wr_t              irf_g;
   logic                 muldiv_ack_g;
   logic                 setcc_g;
   logic [N_THREADS-1:0] longop_done_g;
   logic                 cwp_wen_e;
   sr_wen_t              sr_wen_w;
   logic [7:0]           rdpr_e;

   int tb_errors = 0;
   int directed_cycles = 400;
   int random_cycles = 1500;
   logic [6:0] sr_addrs [7] = '{SR_CCR, SR_CWP, SR_CANSAVE, SR_CANRESTORE,
                                SR_CLEANWIN, SR_OTHERWIN, SR_WSTATE};

   exu_wb_top u_exu_wb_top (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Watchdog sized from the stimulus length
   initial begin
      #((directed_cycles + random_cycles) * 40 + 1000);
      $display("Timeout: the run did not reach its end in time");
      $display("Finished with errors");
      $finish;
   end

   task automatic clear_inputs();
      wen_d = 1'b0;
      wsr_d = 1'b0;
      sraddr_d = '0;
      return_d = 1'b0;
      kill_e = 1'b0;
      inst_vld_e = 1'b1;
      inst_vld_w = 1'b1;
      restore_e = 1'b0;
      fill_e = 1'b0;
      tgt_m = '0;
      kill_m = 1'b0;
      flush_w = 1'b0;
      early_flush_w = 1'b0;
      flush_w1 = 1'b0;
      tid_w1 = '0;
      ld_g = '0;
      ld_miss_g2 = 1'b0;
      muldiv_g = '0;
      win_d = '0;
      cc_d = '0;
   endtask

   task automatic idle(int n);
      repeat (n) @(negedge clk);
   endtask

   task automatic issue_pipe_write(irf_tgt_t tgt, bit ke, bit km, bit fl);
      @(negedge clk) wen_d = 1'b1;
      @(negedge clk) begin
         wen_d = 1'b0;
         kill_e = ke;
      end
      @(negedge clk) begin
         kill_e = 1'b0;
         tgt_m = tgt;
         kill_m = km;
      end
      @(negedge clk) begin
         kill_m = 1'b0;
         flush_w = fl;
      end
      @(negedge clk) flush_w = 1'b0;
   endtask

   // Pipe write two cycles ahead makes the pipe busy when the load reaches G2
   task automatic return_load(irf_tgt_t tgt, bit miss, bit fl, bit with_pipe);
      @(negedge clk) wen_d = with_pipe;
      @(negedge clk) wen_d = 1'b0;
      @(negedge clk) begin
         ld_g.vld = 1'b1;
         ld_g.tgt = tgt;
         tgt_m = irf_tgt_t'(7'($urandom()));
      end
      @(negedge clk) begin
         ld_g = '0;
         ld_miss_g2 = miss;
         flush_w1 = fl;
         tid_w1 = tgt.tid;
      end
      @(negedge clk) begin
         ld_miss_g2 = 1'b0;
         flush_w1 = 1'b0;
      end
   endtask

   task automatic run_muldiv(bit sel_div, irf_tgt_t div_tgt, irf_tgt_t mul_tgt, bit dsc,
                             bit msc);
      int waited;
      @(negedge clk) begin
         muldiv_g.req = 1'b1;
         muldiv_g.sel_div = sel_div;
         muldiv_g.div_tgt = div_tgt;
         muldiv_g.mul_tgt = mul_tgt;
         muldiv_g.div_setcc = dsc;
         muldiv_g.mul_setcc = msc;
      end
      waited = 0;
      while (!muldiv_ack_g && waited < 20) begin
         @(negedge clk);
         waited++;
      end
      if (!muldiv_ack_g) begin
         $display("Multiply/divide request was never acknowledged at %0t", $time);
         tb_errors++;
      end
      @(negedge clk) muldiv_g = '0;
   endtask

   task automatic issue_restore(irf_tgt_t tgt, bit fl);
      int waited;
      bit seen;
      @(negedge clk) wen_d = 1'b1;
      @(negedge clk) begin
         wen_d = 1'b0;
         restore_e = 1'b1;
      end
      @(negedge clk) begin
         restore_e = 1'b0;
         tgt_m = tgt;
      end
      @(negedge clk) flush_w = fl;
      seen = 1'b0;
      waited = 0;
      while (!seen && waited < 20) begin
         if (longop_done_g[tgt.tid]) begin
            seen = 1'b1;
         end else begin
            @(negedge clk) flush_w = 1'b0;
            waited++;
         end
      end
      // Flush stays up through the W-stage edge
      @(negedge clk) flush_w = 1'b0;
      if (!seen) begin
         $display("Restore for thread %0d never completed at %0t", tgt.tid, $time);
         tb_errors++;
      end
      idle(2);
   endtask

   task automatic write_special(logic [6:0] addr);
      @(negedge clk) begin
         wsr_d = 1'b1;
         sraddr_d.raw = addr;
      end
      @(negedge clk) wsr_d = 1'b0;
      idle(4);
   endtask

   task automatic read_special(logic [6:0] addr);
      @(negedge clk) begin
         sraddr_d.raw = addr;
         win_d = 21'($urandom());
         cc_d = 8'($urandom());
      end
   endtask

   task automatic random_traffic(int cycles);
      bit md_taken;
      md_taken = 1'b0;
      repeat (cycles) begin
         @(negedge clk);
         if (muldiv_g.req && md_taken) muldiv_g = '0;
         if (!muldiv_g.req && ($urandom() % 6 == 0)) begin
            muldiv_g = muldiv_wb_t'({1'b1, 17'($urandom())});
         end
         wen_d = 1'($urandom());
         wsr_d = ($urandom() % 10 == 0);
         sraddr_d.raw = ($urandom() % 2 == 0) ? sr_addrs[$urandom() % 7] : 7'($urandom());
         kill_e = ($urandom() % 8 == 0);
         restore_e = ($urandom() % 10 == 0);
         return_d = ($urandom() % 8 == 0);
         fill_e = ($urandom() % 10 == 0);
         inst_vld_e = ($urandom() % 10 != 0);
         inst_vld_w = ($urandom() % 10 != 0);
         tgt_m = irf_tgt_t'(7'($urandom()));
         kill_m = ($urandom() % 8 == 0);
         flush_w = ($urandom() % 12 == 0);
         early_flush_w = ($urandom() % 16 == 0);
         flush_w1 = ($urandom() % 6 == 0);
         tid_w1 = 2'($urandom());
         ld_g = ld_ret_t'({($urandom() % 5 == 0), 7'($urandom())});
         ld_miss_g2 = ($urandom() % 6 == 0);
         win_d = 21'($urandom());
         cc_d = 8'($urandom());
         md_taken = muldiv_g.req && muldiv_ack_g;
      end
   endtask

   initial begin
      int total;
      void'($urandom(95566));
      clear_inputs();
      reset = 1'b1;
      repeat (4) @(negedge clk);
      reset = 1'b0;
      idle(2);

      ////////////////////
      // Directed
      ////////////////////
      issue_pipe_write(7'h25, 1'b0, 1'b0, 1'b0);
      issue_pipe_write(7'h13, 1'b1, 1'b0, 1'b0);
      issue_pipe_write(7'h4a, 1'b0, 1'b1, 1'b0);
      issue_pipe_write(7'h6f, 1'b0, 1'b0, 1'b1);
      return_load(7'h31, 1'b0, 1'b0, 1'b0);
      return_load(7'h52, 1'b0, 1'b0, 1'b1);
      return_load(7'h07, 1'b1, 1'b0, 1'b0);
      return_load(7'h68, 1'b0, 1'b1, 1'b1);
      run_muldiv(1'b1, 7'h45, 7'h12, 1'b1, 1'b0);
      run_muldiv(1'b0, 7'h45, 7'h7c, 1'b1, 1'b0);
      // G held by a load while mul/div waits
      fork
         return_load(7'h2d, 1'b0, 1'b0, 1'b1);
         begin
            idle(3);
            run_muldiv(1'b0, 7'h11, 7'h3e, 1'b0, 1'b1);
         end
      join
      issue_restore(7'h5b, 1'b0);
      issue_restore(7'h1c, 1'b1);
      for (int i = 0; i < 7; i++) write_special(sr_addrs[i]);
      write_special(7'h03);
      for (int i = 0; i < 16; i++) read_special({3'($urandom()), 4'(i)});
      clear_inputs();
      idle(4);

      random_traffic(random_cycles);
      clear_inputs();
      idle(10);

      total = u_exu_wb_top.u_sva.fail_count + tb_errors;
      $display("Error counts: assertions %0d, testbench %0d",
               u_exu_wb_top.u_sva.fail_count, tb_errors);
      if (total == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: tb/exu_wb_sva.sv
// Bound to exu_wb_top; taps restore_req, restore_picked and restore_tgt inside the top level
`timescale 1ns/1ps

module exu_wb_sva import exu_wb_pkg::*; (
   input logic                 clk,
   input logic                 reset,
   input logic                 wen_d,
   input logic                 wsr_d,
   input sr_addr_u             sraddr_d,
   input logic                 return_d,
   input logic                 kill_e,
   input logic                 inst_vld_e,
   input logic                 inst_vld_w,
   input logic                 restore_e,
   input logic                 fill_e,
   input irf_tgt_t             tgt_m,
   input logic                 kill_m,
   input logic                 flush_w,
   input logic                 early_flush_w,
   input logic                 flush_w1,
   input logic [TID_W-1:0]     tid_w1,
   input ld_ret_t              ld_g,
   input logic                 ld_miss_g2,
   input muldiv_wb_t           muldiv_g,
   input win_state_t           win_d,
   input logic [7:0]           cc_d,
   input irf_wr_t              irf_w1,
   input irf_wr_t              irf_g,
   input logic                 muldiv_ack_g,
   input logic                 setcc_g,
   input logic [N_THREADS-1:0] longop_done_g,
   input logic                 cwp_wen_e,
   input sr_wen_t              sr_wen_w,
   input logic [7:0]           rdpr_e,
   input logic                 restore_req,
   input logic                 restore_picked,
   input irf_tgt_t             restore_tgt
);

   int                   fail_count = 0;
   int                   restore_wait;
   logic                 e_wr_q;
   logic                 e_wsr_q;
   logic                 return_q;
   logic                 m_wr_q;
   logic                 m_wsr_q;
   logic                 w_wr_q;
   logic                 w_busy_q;
   irf_tgt_t             tgt_w_q;
   logic                 ld_vld_q;
   irf_tgt_t             ld_tgt_q;
   logic                 rst_m_q;
   logic                 rst_w_q;
   logic                 rst_held_q;
   irf_tgt_t             rst_tgt_q;
   logic                 rst_ok;
   logic                 acc_restore_e;
   logic                 pipe_wr;
   logic                 ld_ok;
   logic                 w_flushed;
   irf_tgt_t             md_tgt;
   logic                 md_setcc;
   logic [N_THREADS-1:0] done_exp;

   function automatic sr_wen_t expected_wen(logic [6:0] addr);
      sr_wen_t e;
      e.ccr        = (addr == SR_CCR);
      e.cansave    = (addr == SR_CANSAVE);
      e.canrestore = (addr == SR_CANRESTORE);
      e.otherwin   = (addr == SR_OTHERWIN);
      e.wstate     = (addr == SR_WSTATE);
      e.cleanwin   = (addr == SR_CLEANWIN);
      return e;
   endfunction

   function automatic logic [7:0] read_value(logic [6:0] addr, win_state_t w, logic [7:0] cc);
      logic [7:0] v;
      if (!addr[3]) begin
         v = cc;
      end else if (addr[3:0] == 4'd9) begin
         v = {5'b0, w.cwp};
      end else if (addr[3:0] == 4'd14) begin
         v = {2'b0, w.wstate};
      end else begin
         case (addr[1:0])
            2'd0:    v = {5'b0, w.cleanwin};
            2'd1:    v = {5'b0, w.otherwin};
            2'd2:    v = {5'b0, w.cansave};
            default: v = {5'b0, w.canrestore};
         endcase
      end
      return v;
   endfunction

   ////////////////////
   // Reference stages
   ////////////////////
   assign acc_restore_e = restore_e & e_wr_q & ~return_q & ~fill_e & inst_vld_e;

   always_ff @(posedge clk) begin
      if (reset) begin
         e_wr_q   <= 1'b0;
         e_wsr_q  <= 1'b0;
         return_q <= 1'b0;
         m_wr_q   <= 1'b0;
         m_wsr_q  <= 1'b0;
         w_wr_q   <= 1'b0;
         w_busy_q <= 1'b0;
         ld_vld_q <= 1'b0;
         rst_m_q  <= 1'b0;
         rst_w_q  <= 1'b0;
         rst_held_q <= 1'b0;
         restore_wait <= 0;
      end else begin
         e_wr_q   <= wen_d;
         e_wsr_q  <= wsr_d;
         return_q <= return_d;
         m_wr_q   <= e_wr_q & ~kill_e & ~restore_e & ~e_wsr_q;
         m_wsr_q  <= e_wsr_q;
         w_wr_q   <= m_wr_q & ~kill_m;
         w_busy_q <= m_wr_q | m_wsr_q;
         ld_vld_q <= ld_g.vld;
         rst_m_q  <= acc_restore_e;
         rst_w_q  <= rst_m_q;
         // A valid restore waits here until a port takes it
         rst_held_q <= rst_ok & ~restore_picked;
         restore_wait <= (restore_req && !restore_picked) ? restore_wait + 1 : 0;
      end
   end

   always_ff @(posedge clk) begin
      tgt_w_q  <= tgt_m;
      ld_tgt_q <= ld_g.tgt;
      if (rst_m_q) begin
         rst_tgt_q <= tgt_m;
      end
   end

   assign pipe_wr   = w_wr_q & ~flush_w & ~early_flush_w & inst_vld_w;
   assign ld_ok     = ld_vld_q & ~ld_miss_g2 & ~(flush_w1 && (tid_w1 == ld_tgt_q.tid));
   assign w_flushed = flush_w | early_flush_w | ~inst_vld_w;
   assign rst_ok    = (rst_w_q & ~w_flushed) | rst_held_q;
   assign md_tgt    = muldiv_g.sel_div ? muldiv_g.div_tgt : muldiv_g.mul_tgt;
   assign md_setcc  = muldiv_g.sel_div ? muldiv_g.div_setcc : muldiv_g.mul_setcc;

   // One done bit per finished mul/div and per picked restore
   always_comb begin
      for (int i = 0; i < N_THREADS; i++) begin
         done_exp[i] = (muldiv_g.req && muldiv_ack_g && md_tgt.tid == i) ||
                       (restore_picked && rst_tgt_q.tid == i);
      end
   end

   ////////////////////
   // Pipeline and loads
   ////////////////////
   a_pipe_write: assert property (@(posedge clk) disable iff (reset)
      pipe_wr |-> irf_w1.wen && irf_w1.tgt == tgt_w_q)
      else begin fail_count++; $error("MISMATCH at %0t: pipeline write missing", $time); end

   a_pipe_kill: assert property (@(posedge clk) disable iff (reset)
      (w_busy_q || (!ld_vld_q && !restore_req)) && !pipe_wr |-> !irf_w1.wen)
      else begin fail_count++; $error("MISMATCH at %0t: unexpected W1 write", $time); end

   a_load_w1: assert property (@(posedge clk) disable iff (reset)
      ld_vld_q && !w_busy_q |-> irf_w1.wen == ld_ok && irf_w1.tgt == ld_tgt_q)
      else begin fail_count++; $error("MISMATCH at %0t: load return on W1", $time); end

   a_load_g: assert property (@(posedge clk) disable iff (reset)
      ld_vld_q && w_busy_q |-> irf_g.wen == ld_ok && irf_g.tgt == ld_tgt_q)
      else begin fail_count++; $error("MISMATCH at %0t: load return on G", $time); end

   ////////////////////
   // Multiply/divide
   ////////////////////
   // G goes to a load when W1 is busy, then to a restore pushed off W1
   a_md_ack: assert property (@(posedge clk) disable iff (reset)
      muldiv_ack_g == (!(ld_vld_q && w_busy_q) && !(restore_req && (ld_vld_q || w_busy_q))))
      else begin fail_count++; $error("MISMATCH at %0t: mul/div acknowledge", $time); end

   a_md_write: assert property (@(posedge clk) disable iff (reset)
      muldiv_g.req && muldiv_ack_g |-> irf_g.wen && irf_g.tgt == md_tgt &&
      setcc_g == md_setcc && longop_done_g[md_tgt.tid])
      else begin fail_count++; $error("MISMATCH at %0t: mul/div writeback", $time); end

   a_md_setcc: assert property (@(posedge clk) disable iff (reset)
      !(muldiv_g.req && muldiv_ack_g) |-> !setcc_g)
      else begin fail_count++; $error("MISMATCH at %0t: stray setcc", $time); end

   ////////////////////
   // Restore
   ////////////////////
   a_rst_capture: assert property (@(posedge clk) disable iff (reset)
      rst_w_q |-> restore_tgt == tgt_w_q)
      else begin fail_count++; $error("MISMATCH at %0t: restore target capture", $time); end

   a_done: assert property (@(posedge clk) disable iff (reset)
      longop_done_g == done_exp)
      else begin fail_count++; $error("MISMATCH at %0t: long-op done bits", $time); end

   a_rst_port: assert property (@(posedge clk) disable iff (reset)
      restore_picked |-> ((!w_busy_q && !ld_vld_q) ? irf_w1 : irf_g) == {rst_ok, rst_tgt_q})
      else begin fail_count++; $error("MISMATCH at %0t: restore port write", $time); end

   a_rst_flush: assert property (@(posedge clk) disable iff (reset)
      rst_w_q && w_flushed && !$past(restore_req) && !w_busy_q && !ld_vld_q |-> !irf_w1.wen)
      else begin fail_count++; $error("MISMATCH at %0t: flushed restore wrote", $time); end

   a_rst_wait: assert property (@(posedge clk) disable iff (reset)
      restore_wait < 12)
      else begin fail_count++; $error("Restore was never given a port at %0t", $time); end

   ////////////////////
   // Special registers and reset
   ////////////////////
   a_sr_wen: assert property (@(posedge clk) disable iff (reset)
      sr_wen_w == ($past(wsr_d, 3) ? expected_wen($past(sraddr_d.raw, 3)) : sr_wen_t'(6'b0)))
      else begin fail_count++; $error("MISMATCH at %0t: special register enable", $time); end

   a_cwp_wen: assert property (@(posedge clk) disable iff (reset)
      cwp_wen_e == ($past(wsr_d) && $past(sraddr_d.raw) == SR_CWP))
      else begin fail_count++; $error("MISMATCH at %0t: cwp enable", $time); end

   a_sr_read: assert property (@(posedge clk) disable iff (reset)
      rdpr_e == read_value($past(sraddr_d.raw), $past(win_d), $past(cc_d)))
      else begin fail_count++; $error("MISMATCH at %0t: special register read", $time); end

   a_reset: assert property (@(posedge clk)
      !reset && $past(reset) |-> !irf_w1.wen && !irf_g.wen && !setcc_g &&
      longop_done_g == '0 && !cwp_wen_e && sr_wen_w == '0)
      else begin fail_count++; $error("MISMATCH at %0t: outputs active after reset", $time); end

endmodule

bind exu_wb_top exu_wb_sva u_sva (.*);

// File: hw/exu_wb_top.sv
// Inputs are assumed stage-aligned by decode; mul/div request must hold until acknowledged
`timescale 1ns/1ps

module exu_wb_top import exu_wb_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 wen_d,
   input  logic                 wsr_d,
   input  sr_addr_u             sraddr_d,
   input  logic                 return_d,
   input  logic                 kill_e,
   input  logic                 inst_vld_e,
   input  logic                 inst_vld_w,
   input  logic                 restore_e,
   input  logic                 fill_e,
   input  irf_tgt_t             tgt_m,
   input  logic                 kill_m,
   input  logic                 flush_w,
   input  logic                 early_flush_w,
   input  logic                 flush_w1,
   input  logic [TID_W-1:0]     tid_w1,
   input  ld_ret_t              ld_g,
   input  logic                 ld_miss_g2,
   input  muldiv_wb_t           muldiv_g,
   input  win_state_t           win_d,
   input  logic [7:0]           cc_d,
   output irf_wr_t              irf_w1,
   output irf_wr_t              irf_g,
   output logic                 muldiv_ack_g,
   output logic                 setcc_g,
   output logic [N_THREADS-1:0] longop_done_g,
   output logic                 cwp_wen_e,
   output sr_wen_t              sr_wen_w,
   output logic [7:0]           rdpr_e
);

   logic     wb_e;
   logic     wrsr_e;
   logic     wrsr_w;
   sr_addr_u sraddr_e;
   sr_addr_u sraddr_w;
   logic     pipe_busy_m;
   logic     pipe_wen_w;
   logic     restore_req;
   logic     restore_wen;
   irf_tgt_t restore_tgt;
   logic     restore_picked;

   wb_pipe_ctl u_pipe (
      .clk(clk), .reset(reset), .wen_d(wen_d), .wsr_d(wsr_d), .sraddr_d(sraddr_d),
      .kill_e(kill_e), .restore_e(restore_e), .kill_m(kill_m), .flush_w(flush_w),
      .early_flush_w(early_flush_w), .wb_e(wb_e), .wrsr_e(wrsr_e), .wb_m(), .wrsr_m(),
      .wrsr_w(wrsr_w), .sraddr_e(sraddr_e), .sraddr_w(sraddr_w),
      .pipe_busy_m(pipe_busy_m), .pipe_wen_w(pipe_wen_w)
   );

   restore_ctl u_restore (
      .clk(clk), .reset(reset), .restore_e(restore_e), .return_d(return_d),
      .fill_e(fill_e), .inst_vld_e(inst_vld_e), .wb_e(wb_e), .inst_vld_w(inst_vld_w),
      .flush_w(flush_w), .early_flush_w(early_flush_w), .tgt_m(tgt_m),
      .restore_picked(restore_picked), .restore_req(restore_req),
      .restore_wen(restore_wen), .restore_tgt(restore_tgt)
   );

   irf_port_arb u_arb (
      .clk(clk), .reset(reset), .ld_g(ld_g), .ld_miss_g2(ld_miss_g2),
      .flush_w1(flush_w1), .tid_w1(tid_w1), .pipe_busy_m(pipe_busy_m),
      .pipe_wen_w(pipe_wen_w), .inst_vld_w(inst_vld_w), .tgt_m(tgt_m),
      .restore_req(restore_req), .restore_wen(restore_wen), .restore_tgt(restore_tgt),
      .muldiv_g(muldiv_g), .irf_w1(irf_w1), .irf_g(irf_g),
      .restore_picked(restore_picked), .muldiv_ack_g(muldiv_ack_g),
      .setcc_g(setcc_g), .longop_done_g(longop_done_g)
   );

   sr_access u_sr (
      .clk(clk), .reset(reset), .wrsr_e(wrsr_e), .wrsr_w(wrsr_w), .sraddr_d(sraddr_d),
      .sraddr_e(sraddr_e), .sraddr_w(sraddr_w), .win_d(win_d), .cc_d(cc_d),
      .cwp_wen_e(cwp_wen_e), .sr_wen_w(sr_wen_w), .rdpr_e(rdpr_e)
   );

endmodule

// File: hw/sr_access.sv
// Writes decode the full 7-bit address; reads decode only the low index, so aliases read back
`timescale 1ns/1ps

module sr_access import exu_wb_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       wrsr_e,
   input  logic       wrsr_w,
   input  sr_addr_u   sraddr_d,
   input  sr_addr_u   sraddr_e,
   input  sr_addr_u   sraddr_w,
   input  win_state_t win_d,
   input  logic [7:0] cc_d,
   output logic       cwp_wen_e,
   output sr_wen_t    sr_wen_w,
   output logic [7:0] rdpr_e
);

   logic [3:0] rd_idx;
   logic [2:0] win_sel;
   logic [7:0] rdpr_d;

   ////////////////////
   // Write enables
   ////////////////////
   // CWP is written early in E, the rest wait for W
   assign cwp_wen_e = wrsr_e & (sraddr_e.raw == SR_CWP);

   assign sr_wen_w.ccr        = wrsr_w & (sraddr_w.raw == SR_CCR);
   assign sr_wen_w.cansave    = wrsr_w & (sraddr_w.raw == SR_CANSAVE);
   assign sr_wen_w.canrestore = wrsr_w & (sraddr_w.raw == SR_CANRESTORE);
   assign sr_wen_w.otherwin   = wrsr_w & (sraddr_w.raw == SR_OTHERWIN);
   assign sr_wen_w.wstate     = wrsr_w & (sraddr_w.raw == SR_WSTATE);
   assign sr_wen_w.cleanwin   = wrsr_w & (sraddr_w.raw == SR_CLEANWIN);

   ////////////////////
   // Read mux
   ////////////////////
   assign rd_idx = sraddr_d.f.idx;

   // Window counters 0xc..0xf and 0xa/0xb share one 3-bit mux on the low bits
   always_comb begin
      case (rd_idx[1:0])
         2'b00:   win_sel = win_d.cleanwin;
         2'b01:   win_sel = win_d.otherwin;
         2'b10:   win_sel = win_d.cansave;
         default: win_sel = win_d.canrestore;
      endcase
   end

   always_comb begin
      if (!rd_idx[3]) begin
         rdpr_d = cc_d;
      end else if (rd_idx == 4'd9) begin
         rdpr_d = 8'(win_d.cwp);
      end else if (rd_idx == 4'd14) begin
         rdpr_d = 8'(win_d.wstate);
      end else begin
         rdpr_d = 8'(win_sel);
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         rdpr_e <= 8'h00;
      end else begin
         rdpr_e <= rdpr_d;
      end
   end

endmodule

// File: hw/irf_port_arb.sv
// Loads never stall; a killed or missed load still holds the port it was given for that cycle
`timescale 1ns/1ps

module irf_port_arb import exu_wb_pkg::*; (
   input  logic                 clk,
   input  logic                 reset,
   input  ld_ret_t              ld_g,
   input  logic                 ld_miss_g2,
   input  logic                 flush_w1,
   input  logic [TID_W-1:0]     tid_w1,
   input  logic                 pipe_busy_m,
   input  logic                 pipe_wen_w,
   input  logic                 inst_vld_w,
   input  irf_tgt_t             tgt_m,
   input  logic                 restore_req,
   input  logic                 restore_wen,
   input  irf_tgt_t             restore_tgt,
   input  muldiv_wb_t           muldiv_g,
   output irf_wr_t              irf_w1,
   output irf_wr_t              irf_g,
   output logic                 restore_picked,
   output logic                 muldiv_ack_g,
   output logic                 setcc_g,
   output logic [N_THREADS-1:0] longop_done_g
);

   logic                 ld_vld_g2;
   irf_tgt_t             ld_tgt_g2;
   logic                 kill_ld_g2;
   logic                 ld_wen_g2;
   logic                 pipe_busy_w;
   irf_tgt_t             tgt_w;
   logic                 sel_load_g;
   logic                 sel_restore_w1;
   logic                 sel_restore_g;
   logic                 sel_muldiv_g;
   logic                 muldiv_fire;
   irf_tgt_t             muldiv_tgt;
   logic [N_THREADS-1:0] muldiv_done;
   logic [N_THREADS-1:0] restore_done;

   ////////////////////
   // Load G2 stage
   ////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         ld_vld_g2   <= 1'b0;
         pipe_busy_w <= 1'b0;
      end else begin
         ld_vld_g2   <= ld_g.vld;
         pipe_busy_w <= pipe_busy_m;
      end
   end

   always_ff @(posedge clk) begin
      ld_tgt_g2 <= ld_g.tgt;
      tgt_w     <= tgt_m;
   end

   // Thread flushed one cycle after W loses its load
   assign kill_ld_g2 = flush_w1 & (ld_tgt_g2.tid == tid_w1);
   assign ld_wen_g2  = ld_vld_g2 & ~kill_ld_g2 & ~ld_miss_g2;

   ////////////////////
   // Port selects
   ////////////////////
   // W1 order is pipe, load, restore and G order is load, restore, mul/div
   assign sel_restore_w1 = ~pipe_busy_w & ~ld_vld_g2;
   assign sel_load_g     = pipe_busy_w & ld_vld_g2;
   assign sel_restore_g  = restore_req & (pipe_busy_w ^ ld_vld_g2);
   assign sel_muldiv_g   = ~(sel_load_g | sel_restore_g);

   assign restore_picked = restore_req & (sel_restore_w1 | sel_restore_g);

   always_comb begin
      if (pipe_busy_w) begin
         irf_w1.wen = pipe_wen_w & inst_vld_w;
         irf_w1.tgt = tgt_w;
      end else if (ld_vld_g2) begin
         irf_w1.wen = ld_wen_g2;
         irf_w1.tgt = ld_tgt_g2;
      end else begin
         irf_w1.wen = restore_wen;
         irf_w1.tgt = restore_tgt;
      end
   end

   ////////////////////
   // G port
   ////////////////////
   assign muldiv_tgt   = muldiv_g.sel_div ? muldiv_g.div_tgt : muldiv_g.mul_tgt;
   assign muldiv_ack_g = sel_muldiv_g;
   assign muldiv_fire  = sel_muldiv_g & muldiv_g.req;

   always_comb begin
      if (sel_load_g) begin
         irf_g.wen = ld_wen_g2;
         irf_g.tgt = ld_tgt_g2;
      end else if (sel_restore_g) begin
         irf_g.wen = restore_wen;
         irf_g.tgt = restore_tgt;
      end else begin
         irf_g.wen = muldiv_g.req;
         irf_g.tgt = muldiv_tgt;
      end
   end

   // Condition codes only update on the cycle the result is taken
   assign setcc_g = muldiv_fire &
                    (muldiv_g.sel_div ? muldiv_g.div_setcc : muldiv_g.mul_setcc);

   ////////////////////
   // Long-op done
   ////////////////////
   assign muldiv_done  = muldiv_fire ? (N_THREADS'(1) << muldiv_tgt.tid) : '0;
   assign restore_done = restore_picked ? (N_THREADS'(1) << restore_tgt.tid) : '0;

   assign longop_done_g = muldiv_done | restore_done;

endmodule

// File: hw/restore_ctl.sv
// One restore may wait at a time; a second restore in W overwrites the captured target
`timescale 1ns/1ps

module restore_ctl import exu_wb_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     restore_e,
   input  logic     return_d,
   input  logic     fill_e,
   input  logic     inst_vld_e,
   input  logic     wb_e,
   input  logic     inst_vld_w,
   input  logic     flush_w,
   input  logic     early_flush_w,
   input  irf_tgt_t tgt_m,
   input  logic     restore_picked,
   output logic     restore_req,
   output logic     restore_wen,
   output irf_tgt_t restore_tgt
);

   logic return_e;
   logic vld_restore_e;
   logic restore_m;
   logic restore_w;
   logic vld_restore_w;
   logic restore_ready;

   // Returns switch the window back on their own, fills never write
   assign vld_restore_e = restore_e & wb_e & ~return_e & ~fill_e & inst_vld_e;

   // Flushed restores still request a port so that the done bit fires
   assign vld_restore_w = restore_w & ~flush_w & ~early_flush_w & inst_vld_w;

   assign restore_req = restore_w | restore_ready;
   assign restore_wen = vld_restore_w | restore_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         return_e      <= 1'b0;
         restore_m     <= 1'b0;
         restore_w     <= 1'b0;
         restore_ready <= 1'b0;
      end else begin
         return_e      <= return_d;
         restore_m     <= vld_restore_e;
         restore_w     <= restore_m;
         // Hold until a port takes it
         restore_ready <= (vld_restore_w | restore_ready) & ~restore_picked;
      end
   end

   // Target is taken from the pipe while the restore sits in M
   always_ff @(posedge clk) begin
      if (restore_m) begin
         restore_tgt <= tgt_m;
      end
   end

endmodule

// File: hw/wb_pipe_ctl.sv
// Write-special flag and address are not killed in the pipe; flushes only qualify the W-stage write
`timescale 1ns/1ps

module wb_pipe_ctl import exu_wb_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     wen_d,
   input  logic     wsr_d,
   input  sr_addr_u sraddr_d,
   input  logic     kill_e,
   input  logic     restore_e,
   input  logic     kill_m,
   input  logic     flush_w,
   input  logic     early_flush_w,
   output logic     wb_e,
   output logic     wrsr_e,
   output logic     wb_m,
   output logic     wrsr_m,
   output logic     wrsr_w,
   output sr_addr_u sraddr_e,
   output sr_addr_u sraddr_w,
   output logic     pipe_busy_m,
   output logic     pipe_wen_w
);

   logic     valid_e;
   logic     valid_m;
   logic     wb_w;
   sr_addr_u sraddr_m;

   ////////////////////
   // E stage
   ////////////////////
   // Restores complete later through their own path
   // and a write-special never writes the register file
   assign valid_e = wb_e & ~kill_e & ~restore_e & ~wrsr_e;

   ////////////////////
   // M stage
   ////////////////////
   assign valid_m = wb_m & ~kill_m;

   // W1 is reserved for anything in M, killed or not
   assign pipe_busy_m = wb_m | wrsr_m;

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_e   <= 1'b0;
         wb_m   <= 1'b0;
         wb_w   <= 1'b0;
         wrsr_e <= 1'b0;
         wrsr_m <= 1'b0;
         wrsr_w <= 1'b0;
      end else begin
         wb_e   <= wen_d;
         wb_m   <= valid_e;
         wb_w   <= valid_m;
         wrsr_e <= wsr_d;
         wrsr_m <= wrsr_e;
         wrsr_w <= wrsr_m;
      end
   end

   // Address follows the write-special flag down the pipe
   always_ff @(posedge clk) begin
      sraddr_e <= sraddr_d;
      sraddr_m <= sraddr_e;
      sraddr_w <= sraddr_m;
   end

   ////////////////////
   // W stage
   ////////////////////
   // inst_vld_w is applied at the port mux
   assign pipe_wen_w = wb_w & ~flush_w & ~early_flush_w;

endmodule

// File: hw/exu_wb_pkg.sv
// Assumes four threads with a 2-bit thread id; only the CCR and register-window addresses decode
package exu_wb_pkg;

   ////////////////////
   // Sizes
   ////////////////////
   localparam int N_THREADS = 4;
   localparam int TID_W     = 2;
   localparam int RD_W      = 5;
   localparam int SRADDR_W  = 7;

   // Special register write addresses
   localparam logic [SRADDR_W-1:0] SR_CCR        = 7'h02;
   localparam logic [SRADDR_W-1:0] SR_CWP        = 7'h29;
   localparam logic [SRADDR_W-1:0] SR_CANSAVE    = 7'h2a;
   localparam logic [SRADDR_W-1:0] SR_CANRESTORE = 7'h2b;
   localparam logic [SRADDR_W-1:0] SR_CLEANWIN   = 7'h2c;
   localparam logic [SRADDR_W-1:0] SR_OTHERWIN   = 7'h2d;
   localparam logic [SRADDR_W-1:0] SR_WSTATE     = 7'h2e;

   ////////////////////
   // Types
   ////////////////////
   typedef struct packed {
      logic [TID_W-1:0] tid;
      logic [RD_W-1:0]  rd;
   } irf_tgt_t;

   // One register file write port
   typedef struct packed {
      logic     wen;
      irf_tgt_t tgt;
   } irf_wr_t;

   // Data fill or alternate-space load coming back
   typedef struct packed {
      logic     vld;
      irf_tgt_t tgt;
   } ld_ret_t;

   typedef struct packed {
      logic     req;
      logic     sel_div;
      irf_tgt_t div_tgt;
      irf_tgt_t mul_tgt;
      logic     div_setcc;
      logic     mul_setcc;
   } muldiv_wb_t;

   typedef struct packed {
      logic [2:0] cwp;
      logic [2:0] cansave;
      logic [2:0] canrestore;
      logic [2:0] otherwin;
      logic [5:0] wstate;
      logic [2:0] cleanwin;
   } win_state_t;

   typedef struct packed {
      logic ccr;
      logic cansave;
      logic canrestore;
      logic otherwin;
      logic wstate;
      logic cleanwin;
   } sr_wen_t;

   // Read decode only looks at the low index
   typedef struct packed {
      logic       hi;
      logic       priv;
      logic       b4;
      logic [3:0] idx;
   } sr_fields_t;

   typedef union packed {
      logic [SRADDR_W-1:0] raw;
      sr_fields_t          f;
   } sr_addr_u;

endpackage
